// ==== hdl/snn_pkg.sv ====
/*
 * SNN core definitions
 * Sizes of the neuron and axon index spaces, the data word width,
 * the saturation limits of the membrane potential and the host
 * region select shared by the status memory, the pipeline and the
 * testbench.
 */
package snn_pkg;

	// ----------------------------------------
	// index widths
	// ----------------------------------------
	// 16 neurons
	localparam int NURN_W = 4;
	// 16 axons per neuron
	localparam int AXON_W = 4;
	// synapse address, neuron index in the upper bits
	localparam int SYN_W = NURN_W + AXON_W;

	// memory depths
	localparam int NUM_NURNS = 2 ** NURN_W;
	localparam int NUM_SYNS = 2 ** SYN_W;

	// ----------------------------------------
	// data word
	// ----------------------------------------
	// signed two's complement everywhere
	localparam int DSIZE = 16;

	// saturation limits for the potential
	localparam logic signed [DSIZE-1:0] POT_MAX = {1'b0, {(DSIZE-1){1'b1}}};
	localparam logic signed [DSIZE-1:0] POT_MIN = {1'b1, {(DSIZE-1){1'b0}}};

	// host region select
	// neuron regions only look at the neuron part of the address
	typedef enum logic [1:0] {
		REG_BIAS    = 2'b00,
		REG_MEMBPOT = 2'b01,
		REG_TH      = 2'b10,
		REG_WEIGHT  = 2'b11
	} mem_region_e;

endpackage

// ==== hdl/status_mem.sv ====
/*
 * Status memory
 * Bias, membrane potential and threshold per neuron, plus one weight
 * per neuron and axon pair. Registered read ports feed the pipeline,
 * the potential memory takes writebacks, and a host port writes and
 * reads every region.
 */
module status_mem (
	input  logic                         clk_i,
	input  logic                         rst_n_i,
	input  logic                         rd_en_i,
	input  logic [snn_pkg::SYN_W-1:0]    rd_syn_addr_i,
	input  logic                         wb_en_i,
	input  logic [snn_pkg::NURN_W-1:0]   wb_nurn_i,
	input  logic [snn_pkg::DSIZE-1:0]    wb_pot_i,
	input  logic                         cfg_we_i,
	input  logic                         cfg_re_i,
	input  snn_pkg::mem_region_e         cfg_sel_i,
	input  logic [snn_pkg::SYN_W-1:0]    cfg_addr_i,
	input  logic [snn_pkg::DSIZE-1:0]    cfg_wdata_i,
	output logic [snn_pkg::DSIZE-1:0]    bias_o,
	output logic [snn_pkg::DSIZE-1:0]    pot_o,
	output logic [snn_pkg::DSIZE-1:0]    th_o,
	output logic [snn_pkg::DSIZE-1:0]    weight_o,
	output logic [snn_pkg::DSIZE-1:0]    cfg_rdata_o
);

	// storage
	logic [snn_pkg::DSIZE-1:0] bias_mem [snn_pkg::NUM_NURNS];
	logic [snn_pkg::DSIZE-1:0] pot_mem [snn_pkg::NUM_NURNS];
	logic [snn_pkg::DSIZE-1:0] th_mem [snn_pkg::NUM_NURNS];
	logic [snn_pkg::DSIZE-1:0] wgt_mem [snn_pkg::NUM_SYNS];

	// neuron part of the pipeline and host addresses
	logic [snn_pkg::NURN_W-1:0] rd_nurn;
	logic [snn_pkg::NURN_W-1:0] cfg_nurn;

	// per region write enables
	logic we_bias;
	logic we_pot;
	logic we_th;
	logic we_wgt;

	// shared potential write port
	logic                       pot_we;
	logic [snn_pkg::NURN_W-1:0] pot_waddr;
	logic [snn_pkg::DSIZE-1:0]  pot_wdata;

	// host read data and the select it was read with
	logic [snn_pkg::DSIZE-1:0] host_bias_q;
	logic [snn_pkg::DSIZE-1:0] host_pot_q;
	logic [snn_pkg::DSIZE-1:0] host_th_q;
	logic [snn_pkg::DSIZE-1:0] host_wgt_q;
	snn_pkg::mem_region_e      cfg_sel_q;

	assign rd_nurn = rd_syn_addr_i[snn_pkg::SYN_W-1:snn_pkg::AXON_W];
	assign cfg_nurn = cfg_addr_i[snn_pkg::SYN_W-1:snn_pkg::AXON_W];

	// ----------------------------------------
	// host write decode
	// ----------------------------------------
	always_comb
	begin
		we_bias = 1'b0;
		we_pot = 1'b0;
		we_th = 1'b0;
		we_wgt = 1'b0;
		if (cfg_we_i)
		begin
			case (cfg_sel_i)
				snn_pkg::REG_BIAS:    we_bias = 1'b1;
				snn_pkg::REG_MEMBPOT: we_pot = 1'b1;
				snn_pkg::REG_TH:      we_th = 1'b1;
				default:              we_wgt = 1'b1;
			endcase
		end
	end

	// writeback owns the port, host only when the pipeline is idle
	assign pot_we = wb_en_i | we_pot;
	assign pot_waddr = wb_en_i ? wb_nurn_i : cfg_nurn;
	assign pot_wdata = wb_en_i ? wb_pot_i : cfg_wdata_i;

	// ----------------------------------------
	// memories and pipeline read ports
	// ----------------------------------------
	always_ff @(posedge clk_i)
	begin
		if (we_bias)
			bias_mem[cfg_nurn] <= cfg_wdata_i;
		if (pot_we)
			pot_mem[pot_waddr] <= pot_wdata;
		if (we_th)
			th_mem[cfg_nurn] <= cfg_wdata_i;
		if (we_wgt)
			wgt_mem[cfg_addr_i] <= cfg_wdata_i;
		// read before write, old data on a same edge hit
		if (rd_en_i)
		begin
			bias_o <= bias_mem[rd_nurn];
			pot_o <= pot_mem[rd_nurn];
			th_o <= th_mem[rd_nurn];
			weight_o <= wgt_mem[rd_syn_addr_i];
		end
	end

	// host read side
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			cfg_sel_q <= snn_pkg::REG_BIAS;
			host_bias_q <= '0;
			host_pot_q <= '0;
			host_th_q <= '0;
			host_wgt_q <= '0;
		end
		else if (cfg_re_i)
		begin
			cfg_sel_q <= cfg_sel_i;
			host_bias_q <= bias_mem[cfg_nurn];
			host_pot_q <= pot_mem[cfg_nurn];
			host_th_q <= th_mem[cfg_nurn];
			host_wgt_q <= wgt_mem[cfg_addr_i];
		end
	end

	// region mux after the register
	always_comb
	begin
		case (cfg_sel_q)
			snn_pkg::REG_BIAS:    cfg_rdata_o = host_bias_q;
			snn_pkg::REG_MEMBPOT: cfg_rdata_o = host_pot_q;
			snn_pkg::REG_TH:      cfg_rdata_o = host_th_q;
			default:              cfg_rdata_o = host_wgt_q;
		endcase
	end

	// potential writes from host and integrate stage never overlap
	a_pot_wr_collision: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(we_pot && wb_en_i))
		else $error("host potential write collides with writeback");

	a_host_rw_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(cfg_we_i && cfg_re_i))
		else $error("host write and read in the same cycle");

endmodule

// ==== hdl/syn_fetch.sv ====
/*
 * Synapse fetch stage
 * Captures an input spike event, forms the synapse address and issues
 * the status memory read, then carries the event on one more cycle to
 * meet the registered memory data.
 */
module syn_fetch (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic                        evt_valid_i,
	input  logic [snn_pkg::NURN_W-1:0]  evt_nurn_i,
	input  logic [snn_pkg::AXON_W-1:0]  evt_axon_i,
	output logic                        rd_en_o,
	output logic [snn_pkg::SYN_W-1:0]   rd_syn_addr_o,
	output logic                        s2_valid_o,
	output logic [snn_pkg::NURN_W-1:0]  s2_nurn_o
);

	// ----------------------------------------
	// event capture
	// ----------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			rd_en_o <= 1'b0;
		else
			rd_en_o <= evt_valid_i;
	end

	// neuron in the upper bits, axon below
	always_ff @(posedge clk_i)
	begin
		if (evt_valid_i)
			rd_syn_addr_o <= {evt_nurn_i, evt_axon_i};
	end

	// ----------------------------------------
	// align with memory read data
	// ----------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			s2_valid_o <= 1'b0;
		else
			s2_valid_o <= rd_en_o;
	end

	// axon no longer needed past the read
	always_ff @(posedge clk_i)
	begin
		if (rd_en_o)
			s2_nurn_o <= rd_syn_addr_o[snn_pkg::SYN_W-1:snn_pkg::AXON_W];
	end

endmodule

// ==== hdl/neuron_integrate.sv ====
/*
 * Neuron integrate stage
 * Adds the synapse weight to the membrane potential with saturation,
 * forwarding from the last two writebacks, fires when the threshold
 * is reached and writes the new potential or the bias back.
 */
module neuron_integrate (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic                        s2_valid_i,
	input  logic [snn_pkg::NURN_W-1:0]  s2_nurn_i,
	input  logic [snn_pkg::DSIZE-1:0]   bias_i,
	input  logic [snn_pkg::DSIZE-1:0]   pot_i,
	input  logic [snn_pkg::DSIZE-1:0]   th_i,
	input  logic [snn_pkg::DSIZE-1:0]   weight_i,
	output logic                        wb_en_o,
	output logic [snn_pkg::NURN_W-1:0]  wb_nurn_o,
	output logic [snn_pkg::DSIZE-1:0]   wb_pot_o,
	output logic                        spike_valid_o,
	output logic [snn_pkg::NURN_W-1:0]  spike_nurn_o
);

	// older writeback record, one cycle behind the wb outputs
	logic                       rec1_en;
	logic [snn_pkg::NURN_W-1:0] rec1_nurn;
	logic [snn_pkg::DSIZE-1:0]  rec1_pot;

	logic signed [snn_pkg::DSIZE-1:0] cur_pot;
	logic signed [snn_pkg::DSIZE:0]   sum_ext;
	logic signed [snn_pkg::DSIZE-1:0] sum_sat;
	logic                             fire;

	// ----------------------------------------
	// forwarding and add
	// ----------------------------------------
	always_comb
	begin
		cur_pot = $signed(pot_i);
		// memory still stale for the two writebacks in flight
		if (rec1_en && rec1_nurn == s2_nurn_i)
			cur_pot = $signed(rec1_pot);
		// newest one wins
		if (wb_en_o && wb_nurn_o == s2_nurn_i)
			cur_pot = $signed(wb_pot_o);
	end

	// one extra bit to catch overflow
	assign sum_ext = {cur_pot[snn_pkg::DSIZE-1], cur_pot}
		+ {weight_i[snn_pkg::DSIZE-1], weight_i};

	always_comb
	begin
		if (sum_ext[snn_pkg::DSIZE] == sum_ext[snn_pkg::DSIZE-1])
			sum_sat = sum_ext[snn_pkg::DSIZE-1:0];
		else if (sum_ext[snn_pkg::DSIZE])
			sum_sat = snn_pkg::POT_MIN;
		else
			sum_sat = snn_pkg::POT_MAX;
	end

	// signed compare against threshold
	assign fire = sum_sat >= $signed(th_i);

	// ----------------------------------------
	// result registers
	// ----------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wb_en_o <= 1'b0;
			spike_valid_o <= 1'b0;
			rec1_en <= 1'b0;
		end
		else
		begin
			wb_en_o <= s2_valid_i;
			spike_valid_o <= s2_valid_i & fire;
			rec1_en <= wb_en_o;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (s2_valid_i)
		begin
			wb_nurn_o <= s2_nurn_i;
			spike_nurn_o <= s2_nurn_i;
			// firing resets to bias
			wb_pot_o <= fire ? bias_i : sum_sat;
		end
		rec1_nurn <= wb_nurn_o;
		rec1_pot <= wb_pot_o;
	end

endmodule

// ==== hdl/snn_core_top.sv ====
/*
 * SNN core top level
 * Connects the synapse fetch stage, the status memory and the neuron
 * integrate stage. Fixed three cycle latency from event to spike.
 */
module snn_core_top (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	// spike events in
	input  logic                        evt_valid_i,
	input  logic [snn_pkg::NURN_W-1:0]  evt_nurn_i,
	input  logic [snn_pkg::AXON_W-1:0]  evt_axon_i,
	// host access
	input  logic                        cfg_we_i,
	input  logic                        cfg_re_i,
	input  snn_pkg::mem_region_e        cfg_sel_i,
	input  logic [snn_pkg::SYN_W-1:0]   cfg_addr_i,
	input  logic [snn_pkg::DSIZE-1:0]   cfg_wdata_i,
	output logic [snn_pkg::DSIZE-1:0]   cfg_rdata_o,
	// spikes out
	output logic                        spike_valid_o,
	output logic [snn_pkg::NURN_W-1:0]  spike_nurn_o
);

	// fetch to memory
	logic                       rd_en;
	logic [snn_pkg::SYN_W-1:0]  rd_syn_addr;
	// fetch to integrate
	logic                       s2_valid;
	logic [snn_pkg::NURN_W-1:0] s2_nurn;
	// memory to integrate
	logic [snn_pkg::DSIZE-1:0]  bias;
	logic [snn_pkg::DSIZE-1:0]  pot;
	logic [snn_pkg::DSIZE-1:0]  th;
	logic [snn_pkg::DSIZE-1:0]  weight;
	// integrate writeback
	logic                       wb_en;
	logic [snn_pkg::NURN_W-1:0] wb_nurn;
	logic [snn_pkg::DSIZE-1:0]  wb_pot;

	syn_fetch u_fetch (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.evt_valid_i(evt_valid_i), .evt_nurn_i(evt_nurn_i), .evt_axon_i(evt_axon_i),
		.rd_en_o(rd_en), .rd_syn_addr_o(rd_syn_addr),
		.s2_valid_o(s2_valid), .s2_nurn_o(s2_nurn)
	);

	status_mem u_mem (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.rd_en_i(rd_en), .rd_syn_addr_i(rd_syn_addr),
		.wb_en_i(wb_en), .wb_nurn_i(wb_nurn), .wb_pot_i(wb_pot),
		.cfg_we_i(cfg_we_i), .cfg_re_i(cfg_re_i), .cfg_sel_i(cfg_sel_i),
		.cfg_addr_i(cfg_addr_i), .cfg_wdata_i(cfg_wdata_i),
		.bias_o(bias), .pot_o(pot), .th_o(th), .weight_o(weight),
		.cfg_rdata_o(cfg_rdata_o)
	);

	neuron_integrate u_integ (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.s2_valid_i(s2_valid), .s2_nurn_i(s2_nurn),
		.bias_i(bias), .pot_i(pot), .th_i(th), .weight_i(weight),
		.wb_en_o(wb_en), .wb_nurn_o(wb_nurn), .wb_pot_o(wb_pot),
		.spike_valid_o(spike_valid_o), .spike_nurn_o(spike_nurn_o)
	);

endmodule

// ==== testbench/tb_snn_core.sv ====
/*
 * SNN core testbench
 * Loads the core through the host port, replays a table of host
 * accesses and spike events, and checks spikes and read data against
 * a reference model of the integrate and fire rule.
 */
module tb_snn_core;
	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [1:0] {OP_IDLE, OP_WR, OP_RD, OP_EVT} op_e;

	// expected spike column of the table
	localparam logic [1:0] SPK_NO = 2'd0;
	localparam logic [1:0] SPK_YES = 2'd1;
	// random section, model decides
	localparam logic [1:0] SPK_MODEL = 2'd2;

	typedef struct packed {
		op_e                         op;
		snn_pkg::mem_region_e        sel;
		logic [snn_pkg::SYN_W-1:0]   addr;
		logic [snn_pkg::DSIZE-1:0]   data;
		logic [1:0]                  spk;
		int                          test;
	} step_t;

	typedef struct packed {
		logic                        vld;
		logic [snn_pkg::NURN_W-1:0]  nurn;
	} spike_t;

	logic                        clk_i = 1'b0;
	logic                        rst_n_i;
	logic                        evt_valid_i;
	logic [snn_pkg::NURN_W-1:0]  evt_nurn_i;
	logic [snn_pkg::AXON_W-1:0]  evt_axon_i;
	logic                        cfg_we_i;
	logic                        cfg_re_i;
	snn_pkg::mem_region_e        cfg_sel_i;
	logic [snn_pkg::SYN_W-1:0]   cfg_addr_i;
	logic [snn_pkg::DSIZE-1:0]   cfg_wdata_i;
	logic [snn_pkg::DSIZE-1:0]   cfg_rdata_o;
	logic                        spike_valid_o;
	logic [snn_pkg::NURN_W-1:0]  spike_nurn_o;

	// reference model state
	logic [snn_pkg::DSIZE-1:0] m_bias [snn_pkg::NUM_NURNS];
	logic [snn_pkg::DSIZE-1:0] m_pot [snn_pkg::NUM_NURNS];
	logic [snn_pkg::DSIZE-1:0] m_th [snn_pkg::NUM_NURNS];
	logic [snn_pkg::DSIZE-1:0] m_wgt [snn_pkg::NUM_SYNS];

	step_t  steps[$];
	string  test_names[$];
	// one entry per cycle, popped three cycles later
	spike_t pipe[$];

	int errs = 0;
	int checks = 0;
	int cycles = 0;
	int timeout_cycles = 0;
	int build_test = 0;
	logic [31:0] rnd = 32'h81ad_4fd7;
	logic rd_pending = 1'b0;
	logic rd_seen = 1'b0;
	logic [snn_pkg::DSIZE-1:0] rd_exp;

	snn_core_top dut (.*);

	always #4 clk_i = ~clk_i;

	// run limit
	always @(posedge clk_i)
	begin
		cycles <= cycles + 1;
		if (timeout_cycles > 0 && cycles >= timeout_cycles)
		begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// model helpers
	// ----------------------------------------
	function automatic logic [31:0] next_rand(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// clamp at the 16 bit signed limits
	function automatic logic [15:0] saturating_add(input logic [15:0] pot, input logic [15:0] w);
		int s;
		s = int'($signed(pot)) + int'($signed(w));
		if (s > 32767)
			return 16'h7fff;
		if (s < -32768)
			return 16'h8000;
		return s[15:0];
	endfunction

	function automatic logic [15:0] model_value(input snn_pkg::mem_region_e sel,
		input logic [7:0] addr);
		case (sel)
			snn_pkg::REG_BIAS:    return m_bias[addr[7:4]];
			snn_pkg::REG_MEMBPOT: return m_pot[addr[7:4]];
			snn_pkg::REG_TH:      return m_th[addr[7:4]];
			default:              return m_wgt[addr];
		endcase
	endfunction

	// ----------------------------------------
	// table building
	// ----------------------------------------
	task automatic append_step(input op_e op, input snn_pkg::mem_region_e sel,
		input logic [7:0] addr, input logic [15:0] data, input logic [1:0] spk);
		step_t st;
		st.op = op;
		st.sel = sel;
		st.addr = addr;
		st.data = data;
		st.spk = spk;
		st.test = build_test;
		steps.push_back(st);
	endtask

	task automatic cfg_write(input snn_pkg::mem_region_e sel, input logic [7:0] addr,
		input logic [15:0] data);
		append_step(OP_WR, sel, addr, data, SPK_NO);
	endtask

	task automatic cfg_read(input snn_pkg::mem_region_e sel, input logic [7:0] addr);
		append_step(OP_RD, sel, addr, 16'h0, SPK_NO);
	endtask

	task automatic neuron_event(input logic [3:0] n, input logic [3:0] a, input logic [1:0] spk);
		append_step(OP_EVT, snn_pkg::REG_BIAS, {n, a}, 16'h0, spk);
	endtask

	task automatic idle_for(input int k);
		repeat (k) append_step(OP_IDLE, snn_pkg::REG_BIAS, 8'h0, 16'h0, SPK_NO);
	endtask

	task automatic begin_test(input string name);
		test_names.push_back(name);
		build_test = test_names.size() - 1;
	endtask

	task automatic build_table();
		begin_test("reset and host access");
		idle_for(3);
		for (int n = 0; n < 16; n++)
		begin
			cfg_write(snn_pkg::REG_BIAS, {4'(n), 4'h0}, 16'(n * 2));
			cfg_write(snn_pkg::REG_MEMBPOT, {4'(n), 4'h0}, 16'h0);
			cfg_write(snn_pkg::REG_TH, {4'(n), 4'h0}, 16'(256 + n * 16));
		end
		cfg_write(snn_pkg::REG_WEIGHT, {4'd1, 4'd2}, 16'h1234);
		cfg_read(snn_pkg::REG_BIAS, {4'd3, 4'd0});
		cfg_read(snn_pkg::REG_MEMBPOT, {4'd3, 4'd0});
		cfg_read(snn_pkg::REG_TH, {4'd15, 4'd0});
		cfg_read(snn_pkg::REG_WEIGHT, {4'd1, 4'd2});
		// axon bits ignored for neuron regions
		cfg_read(snn_pkg::REG_TH, {4'd6, 4'd9});
		idle_for(2);

		begin_test("below threshold");
		cfg_write(snn_pkg::REG_WEIGHT, {4'd2, 4'd0}, 16'h0030);
		cfg_write(snn_pkg::REG_WEIGHT, {4'd2, 4'd1}, 16'h0040);
		neuron_event(4'd2, 4'd0, SPK_NO);
		idle_for(2);
		neuron_event(4'd2, 4'd1, SPK_NO);
		idle_for(4);
		cfg_read(snn_pkg::REG_MEMBPOT, {4'd2, 4'd0});
		idle_for(2);

		begin_test("threshold fire");
		cfg_write(snn_pkg::REG_BIAS, {4'd5, 4'd0}, 16'h000a);
		cfg_write(snn_pkg::REG_TH, {4'd5, 4'd0}, 16'h0150);
		cfg_write(snn_pkg::REG_WEIGHT, {4'd5, 4'd3}, 16'h0100);
		neuron_event(4'd5, 4'd3, SPK_NO);
		idle_for(4);
		cfg_read(snn_pkg::REG_MEMBPOT, {4'd5, 4'd0});
		neuron_event(4'd5, 4'd3, SPK_YES);
		idle_for(4);
		cfg_read(snn_pkg::REG_MEMBPOT, {4'd5, 4'd0});
		idle_for(2);

		begin_test("same neuron back to back");
		cfg_write(snn_pkg::REG_TH, {4'd7, 4'd0}, 16'h0170);
		cfg_write(snn_pkg::REG_WEIGHT, {4'd7, 4'd0}, 16'h0050);
		cfg_write(snn_pkg::REG_WEIGHT, {4'd7, 4'd1}, 16'h0060);
		cfg_write(snn_pkg::REG_WEIGHT, {4'd8, 4'd0}, 16'h0010);
		// consecutive hits on neuron 7
		neuron_event(4'd7, 4'd0, SPK_NO);
		neuron_event(4'd7, 4'd1, SPK_NO);
		neuron_event(4'd7, 4'd0, SPK_NO);
		idle_for(1);
		neuron_event(4'd7, 4'd1, SPK_NO);
		// one cycle apart, older record
		neuron_event(4'd8, 4'd0, SPK_NO);
		neuron_event(4'd7, 4'd0, SPK_YES);
		neuron_event(4'd7, 4'd1, SPK_NO);
		idle_for(4);
		cfg_read(snn_pkg::REG_MEMBPOT, {4'd7, 4'd0});
		cfg_read(snn_pkg::REG_MEMBPOT, {4'd8, 4'd0});
		idle_for(2);

		begin_test("saturation");
		cfg_write(snn_pkg::REG_MEMBPOT, {4'd9, 4'd0}, 16'h7f00);
		cfg_write(snn_pkg::REG_TH, {4'd9, 4'd0}, 16'h7fff);
		cfg_write(snn_pkg::REG_WEIGHT, {4'd9, 4'd0}, 16'h7000);
		cfg_write(snn_pkg::REG_MEMBPOT, {4'd10, 4'd0}, 16'h8100);
		cfg_write(snn_pkg::REG_TH, {4'd10, 4'd0}, 16'h0100);
		cfg_write(snn_pkg::REG_WEIGHT, {4'd10, 4'd0}, 16'h9000);
		// a wrap would go negative and stay silent
		neuron_event(4'd9, 4'd0, SPK_YES);
		neuron_event(4'd10, 4'd0, SPK_NO);
		neuron_event(4'd10, 4'd0, SPK_NO);
		idle_for(4);
		cfg_read(snn_pkg::REG_MEMBPOT, {4'd10, 4'd0});
		cfg_read(snn_pkg::REG_MEMBPOT, {4'd9, 4'd0});
		idle_for(2);

		begin_test("random stream");
		for (int n = 0; n < 16; n++)
		begin
			cfg_write(snn_pkg::REG_MEMBPOT, {4'(n), 4'h0}, 16'h0);
			cfg_write(snn_pkg::REG_TH, {4'(n), 4'h0}, 16'(256 + n * 16));
		end
		// axons 0 to 3 of every neuron, mostly positive
		for (int n = 0; n < 16; n++)
			for (int a = 0; a < 4; a++)
			begin
				rnd = next_rand(rnd);
				cfg_write(snn_pkg::REG_WEIGHT, {4'(n), 4'(a)}, {8'h00, rnd[7:0]} - 16'd40);
			end
		for (int i = 0; i < 120; i++)
		begin
			rnd = next_rand(rnd);
			if (rnd[31:29] == 3'd0)
				idle_for(1);
			else
				neuron_event(rnd[3:0], {2'b00, rnd[5:4]}, SPK_MODEL);
		end
		idle_for(4);
		for (int n = 0; n < 16; n++)
			cfg_read(snn_pkg::REG_MEMBPOT, {4'(n), 4'h0});
		idle_for(2);
	endtask

	task automatic report_test(input int idx, input int nerr);
		if (nerr == 0)
			$display("test %0d %s: passed", idx, test_names[idx]);
		else
			$display("test %0d %s: failed with %0d errors", idx, test_names[idx], nerr);
	endtask

	// ----------------------------------------
	// table replay
	// ----------------------------------------
	initial
	begin
		step_t st;
		spike_t e;
		logic [15:0] nxt;
		logic fire_m;
		logic [3:0] n;
		int cur_test;
		int test_err0;

		rst_n_i = 1'b0;
		evt_valid_i = 1'b0;
		evt_nurn_i = '0;
		evt_axon_i = '0;
		cfg_we_i = 1'b0;
		cfg_re_i = 1'b0;
		cfg_sel_i = snn_pkg::REG_BIAS;
		cfg_addr_i = '0;
		cfg_wdata_i = '0;
		build_table();
		timeout_cycles = steps.size() + 200;
		repeat (10) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;
		cur_test = 0;
		test_err0 = 0;

		for (int i = 0; i < steps.size(); i++)
		begin
			st = steps[i];
			// spike output three cycles after its event
			if (pipe.size() == 3)
			begin
				e = pipe.pop_front();
				checks++;
				if (spike_valid_o !== e.vld)
				begin
					errs++;
					$display("ERR spike_valid_o expected %h got %h", e.vld, spike_valid_o);
				end
				else if (e.vld && spike_nurn_o !== e.nurn)
				begin
					errs++;
					$display("ERR spike_nurn_o expected %h got %h", e.nurn, spike_nurn_o);
				end
			end
			// host read data one cycle after the strobe
			if (rd_pending || !rd_seen)
			begin
				checks++;
				if (cfg_rdata_o !== (rd_pending ? rd_exp : 16'h0))
				begin
					errs++;
					$display("ERR cfg_rdata_o expected %h got %h",
						rd_pending ? rd_exp : 16'h0, cfg_rdata_o);
				end
				rd_pending = 1'b0;
			end
			if (st.test != cur_test)
			begin
				report_test(cur_test, errs - test_err0);
				cur_test = st.test;
				test_err0 = errs;
			end

			evt_valid_i = 1'b0;
			cfg_we_i = 1'b0;
			cfg_re_i = 1'b0;
			e = '0;
			case (st.op)
				OP_WR:
				begin
					cfg_we_i = 1'b1;
					cfg_sel_i = st.sel;
					cfg_addr_i = st.addr;
					cfg_wdata_i = st.data;
					case (st.sel)
						snn_pkg::REG_BIAS:    m_bias[st.addr[7:4]] = st.data;
						snn_pkg::REG_MEMBPOT: m_pot[st.addr[7:4]] = st.data;
						snn_pkg::REG_TH:      m_th[st.addr[7:4]] = st.data;
						default:              m_wgt[st.addr] = st.data;
					endcase
				end
				OP_RD:
				begin
					cfg_re_i = 1'b1;
					cfg_sel_i = st.sel;
					cfg_addr_i = st.addr;
					rd_exp = model_value(st.sel, st.addr);
					rd_pending = 1'b1;
					rd_seen = 1'b1;
				end
				OP_EVT:
				begin
					evt_valid_i = 1'b1;
					evt_nurn_i = st.addr[7:4];
					evt_axon_i = st.addr[3:0];
					n = st.addr[7:4];
					// integrate, fire resets to bias
					nxt = saturating_add(m_pot[n], m_wgt[st.addr]);
					fire_m = $signed(nxt) >= $signed(m_th[n]);
					m_pot[n] = fire_m ? m_bias[n] : nxt;
					if (st.spk != SPK_MODEL && st.spk != {1'b0, fire_m})
					begin
						errs++;
						$display("step %0d: table expects spike %0d on neuron %0d but the model gives %0d",
							i, st.spk, n, fire_m);
					end
					e.vld = fire_m;
					e.nurn = n;
				end
				default:
				begin
				end
			endcase
			pipe.push_back(e);
			@(posedge clk_i);
			#1;
		end

		report_test(cur_test, errs - test_err0);
		$display("%0d tests, %0d checks, %0d errors", test_names.size(), checks, errs);
		if (errs == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
hdl/snn_pkg.sv
hdl/status_mem.sv
hdl/syn_fetch.sv
hdl/neuron_integrate.sv
hdl/snn_core_top.sv
testbench/tb_snn_core.sv

// ==== Makefile ====
# Verilator build and run of the SNN core testbench

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_snn_core
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
